// File: tests/mover_input.txt
# kind sq_x sq_y ci_x ci_y hx_x hx_y frames pick0 pick1 pick2 pick3 colour_seq(hex)
# kind 0 idle, 1 square move, 2 hexagon only over four colours, 3 pump window, 4 park priority
0 103 120 0 0 0 0 0 0 0 0 0 0
1 103 120 0 0 0 0 16 1410 1610 1290 910 1
1 150 180 0 0 0 0 16 1433 1640 1260 933 1
2 0 0 0 0 91 110 64 1404 1605 1295 904 1230
3 103 120 0 0 0 0 16 1410 1610 1290 910 1
4 120 140 0 0 0 0 20 1418 1620 1280 918 1

// File: flist.f
common/mover_pkg.sv
sequencer/job_scheduler.sv
sequencer/pick_place_seq.sv
sequencer/park_seq.sv
servo_link/servo_arbiter.sv
servo_link/servo_uart_tx.sv
source/full_mover.sv
tests/full_mover_checker.sv
tests/full_mover_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f flist.f --top-module full_mover_tb

obj_dir/full_mover_sim: flist.f
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module full_mover_tb -o full_mover_sim

sim: obj_dir/full_mover_sim
	./obj_dir/full_mover_sim | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/full_mover_tb.sv
`timescale 1ns/1ps

module full_mover_tb;

    localparam int baud_div = 4;
    localparam int settle_unit = 8;
    localparam int clk_period = 100;
    localparam int max_tests = 32;

    logic clk_slow = 1'b0;
    logic rst_n;
    logic [mover_pkg::coord_x_w-1:0] square_x;
    logic [mover_pkg::coord_x_w-1:0] circle_x;
    logic [mover_pkg::coord_x_w-1:0] hexagon_x;
    logic [mover_pkg::coord_y_w-1:0] square_y;
    logic [mover_pkg::coord_y_w-1:0] circle_y;
    logic [mover_pkg::coord_y_w-1:0] hexagon_y;
    logic process_ok;
    logic en;
    logic move_to_home;
    mover_pkg::color_t color_select;
    logic pump_enable;
    logic mov_complete;
    logic sub_module_reset;
    logic uart_pin;

    int kind_a[max_tests];
    int frames_a[max_tests];
    int coord_a[max_tests][6];
    int pick_a[max_tests][4];
    logic [15:0] colseq_a[max_tests];
    int n_tests = 0;
    logic loaded = 1'b0;

    logic [39:0] rx_frames[$];
    logic rx_pump[$];
    logic [39:0] rx_word;
    int rx_byte_cnt = 0;
    logic rx_pump_start;
    int completes = 0;
    logic [15:0] col_seq = '0;
    int resets_seen = 0;
    int errors = 0;
    int passed = 0;
    logic [31:0] rnd_state = 32'd84;
    int cur_pick[4];
    int move_order[16] = '{0, 3, 2, 1, 1, 2, 3, 0, 0, 3, 2, 1, 1, 2, 3, 0};
    int park_order[4] = '{1, 2, 0, 3};

    full_mover #(
        .baud_div(baud_div),
        .settle_unit(settle_unit)
    ) full_mover_inst (
        .clk_slow(clk_slow),
        .rst_n(rst_n),
        .square_x(square_x),
        .square_y(square_y),
        .circle_x(circle_x),
        .circle_y(circle_y),
        .hexagon_x(hexagon_x),
        .hexagon_y(hexagon_y),
        .color_select(color_select),
        .process_ok(process_ok),
        .en(en),
        .move_to_home(move_to_home),
        .pump_enable(pump_enable),
        .mov_complete(mov_complete),
        .sub_module_reset(sub_module_reset),
        .uart_pin(uart_pin)
    );

    always #(clk_period / 2) clk_slow = ~clk_slow;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // expected frame with the header byte first
    function automatic logic [39:0] park_frame(input int joint);
        int angle;
        angle = mover_pkg::park_angle_tbl[joint];
        return {8'h55, mover_pkg::servo_id_tbl[joint], 16'(angle), 8'd3};
    endfunction

    function automatic logic [39:0] move_frame(input int k, input int colour, input int shape);
        int joint;
        int angle;
        logic [7:0] t;
        joint = move_order[k];
        case (k / 4)
            0:
            begin
                angle = cur_pick[joint];
                t = 8'd8;
            end
            2:
            begin
                angle = mover_pkg::place_base[joint] + colour * 64 + shape * 16;
                t = 8'd5;
            end
            default:
                return park_frame(joint);
        endcase
        return {8'h55, mover_pkg::servo_id_tbl[joint], 16'(angle), t};
    endfunction

    task automatic check(input string name, input logic [39:0] exp, input logic [39:0] act);
        if (exp !== act)
        begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // uart decoder sampling near mid-bit on the falling clock edge
    always
    begin
        logic [7:0] data;
        @(negedge uart_pin);
        repeat (2) @(negedge clk_slow);
        if (rx_byte_cnt == 0)
            rx_pump_start = pump_enable;                // pump state at frame start
        for (int i = 0; i < 8; i++)
        begin
            repeat (baud_div) @(negedge clk_slow);
            data[i] = uart_pin;
        end
        repeat (baud_div) @(negedge clk_slow);
        if (uart_pin !== 1'b1)
        begin
            $display("uart framing error, stop bit not high");
            errors++;
        end
        rx_word = {rx_word[31:0], data};
        rx_byte_cnt++;
        if (rx_byte_cnt == 5)
        begin
            rx_frames.push_back(rx_word);
            rx_pump.push_back(rx_pump_start);
            rx_byte_cnt = 0;
        end
    end

    always @(negedge clk_slow)
    begin
        if (mov_complete)
        begin
            completes++;
            col_seq = {col_seq[11:0], 2'b00, color_select};
        end
    end

    always @(posedge sub_module_reset)
        resets_seen++;

    initial
    begin
        wait (loaded);
        #(64.0 * n_tests * (50 * baud_div + 8 * settle_unit) * clk_period + 1000 * clk_period);
        $display("timeout, the DUT stopped producing the expected frames");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic run_test(input int t);
        int errs_before;
        int kind;
        int exp;
        int guard;
        int k;
        logic low_seen;
        logic [39:0] want;
        errs_before = errors;
        kind = kind_a[t];
        exp = frames_a[t];
        for (int j = 0; j < 4; j++)
            cur_pick[j] = pick_a[t][j];
        @(negedge clk_slow);
        rx_frames.delete();
        rx_pump.delete();
        completes = 0;
        col_seq = '0;
        resets_seen = 0;
        square_x = coord_a[t][0];
        square_y = coord_a[t][1];
        circle_x = coord_a[t][2];
        circle_y = coord_a[t][3];
        hexagon_x = coord_a[t][4];
        hexagon_y = coord_a[t][5];
        if (kind == 2)
        begin
            rnd_state = xorshift(rnd_state);
            square_x = rnd_state[8:0] | 9'd1;           // no square since y stays zero
            rnd_state = xorshift(rnd_state);
            circle_y = rnd_state[7:0] | 8'd1;
        end
        if (kind == 0)
        begin
            low_seen = 1'b0;
            repeat (200)
            begin
                @(negedge clk_slow);
                if (uart_pin !== 1'b1)
                    low_seen = 1'b1;
            end
            check("uart_pin_low_seen", 40'd0, 40'(low_seen));
        end
        else
        begin
            en = 1'b1;
            process_ok = 1'b1;
            if (kind == 4)
            begin
                while (rx_frames.size() < 5)
                    @(negedge clk_slow);
                move_to_home = 1'b1;                    // mid move
            end
            while (completes < ((kind == 2) ? 4 : 1))
                @(negedge clk_slow);
            process_ok = 1'b0;
        end
        guard = 0;
        while (rx_frames.size() < exp && guard < 4000)
        begin
            @(negedge clk_slow);
            guard++;
        end
        repeat (50 * baud_div + 8 * settle_unit + 20) @(negedge clk_slow);  // room for one more frame
        check("frame_count", 40'(exp), 40'(rx_frames.size()));
        for (int i = 0; i < rx_frames.size() && i < exp; i++)
        begin
            if (kind == 2)
                want = move_frame(i % 16, i / 16, 2);
            else if (kind == 4 && i >= 5 && i < 9)
                want = park_frame(park_order[i - 5]);
            else
            begin
                k = (kind == 4 && i >= 9) ? i - 4 : i;
                want = move_frame(k, 0, 0);
            end
            check($sformatf("frame[%0d]", i), want, rx_frames[i]);
            if (kind == 3 && i != 3 && i != 12)
                check($sformatf("pump_enable@frame[%0d]", i), 40'(i > 3 && i < 12),
                      40'(rx_pump[i]));
        end
        if (kind != 0)
            check("color_select_seq", 40'(colseq_a[t]), 40'(col_seq));
        if (kind == 2)
            check("sub_module_reset_pulses", 40'd5, 40'(resets_seen));
        en = 1'b0;
        move_to_home = 1'b0;
        repeat (4) @(negedge clk_slow);
        check("color_select", 40'd0, 40'(color_select));
        if (errors == errs_before)
            passed++;
        $display("test %0d kind %0d %s", t, kind, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial
    begin
        int fd;
        int r;
        string line;
        int v[13];
        logic [15:0] cs;
        rst_n = 1'b0;
        en = 1'b0;
        process_ok = 1'b0;
        move_to_home = 1'b0;
        square_x = '0;
        square_y = '0;
        circle_x = '0;
        circle_y = '0;
        hexagon_x = '0;
        hexagon_y = '0;
        fd = $fopen("tests/mover_input.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file tests/mover_input.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end
        else
        begin
            while (!$feof(fd) && n_tests < max_tests)
            begin
                line = "";
                r = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#")
                begin
                    r = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %h", v[0], v[1],
                                v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], cs);
                    if (r == 13)
                    begin
                        kind_a[n_tests] = v[0];
                        for (int j = 0; j < 6; j++)
                            coord_a[n_tests][j] = v[1 + j];
                        frames_a[n_tests] = v[7];
                        for (int j = 0; j < 4; j++)
                            pick_a[n_tests][j] = v[8 + j];
                        colseq_a[n_tests] = cs;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (8) @(posedge clk_slow);
            @(negedge clk_slow);
            rst_n = 1'b1;
            for (int t = 0; t < n_tests; t++)
                run_test(t);
            $display("tests %0d passed %0d failed %0d errors %0d", n_tests, passed,
                     n_tests - passed, errors);
            if (errors == 0 && n_tests > 0)
                $display("*** TEST PASSED ***");
            else
                $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// File: tests/full_mover_checker.sv
`timescale 1ns/1ps

module full_mover_checker (
    input logic        clk_slow,
    input logic        rst_n,
    input logic        park_valid,
    input logic        park_ready,
    input logic        pick_valid,
    input logic        pick_ready,
    input logic [39:0] park_frame,
    input logic [39:0] pick_frame
);

    park_holds: assert property (@(posedge clk_slow) disable iff (!rst_n)
        park_valid && !park_ready |=> park_valid)
        else $error("park valid dropped before ready");

    pick_holds: assert property (@(posedge clk_slow) disable iff (!rst_n)
        pick_valid && !pick_ready |=> pick_valid)
        else $error("pick valid dropped before ready");

    // grant taken one cycle before the transfer
    park_priority: assert property (@(posedge clk_slow) disable iff (!rst_n)
        pick_valid && pick_ready |-> !$past(park_valid))
        else $error("pick command granted while park was waiting");

    park_frame_stable: assert property (@(posedge clk_slow) disable iff (!rst_n)
        park_valid && !park_ready |=> $stable(park_frame))
        else $error("park frame changed while waiting");

    pick_frame_stable: assert property (@(posedge clk_slow) disable iff (!rst_n)
        pick_valid && !pick_ready |=> $stable(pick_frame))
        else $error("pick frame changed while waiting");

endmodule

bind servo_arbiter full_mover_checker arbiter_check_inst (
    .clk_slow(clk_slow),
    .rst_n(rst_n),
    .park_valid(park_valid),
    .park_ready(park_ready),
    .pick_valid(pick_valid),
    .pick_ready(pick_ready),
    .park_frame(park_frame),
    .pick_frame(pick_frame)
);

// File: source/full_mover.sv
`timescale 1ns/1ps

module full_mover #(
    parameter int baud_div = 4,
    parameter int settle_unit = 8
) (
    input  logic                                clk_slow,
    input  logic                                rst_n,
    input  logic [mover_pkg::coord_x_w-1:0]     square_x,
    input  logic [mover_pkg::coord_y_w-1:0]     square_y,
    input  logic [mover_pkg::coord_x_w-1:0]     circle_x,
    input  logic [mover_pkg::coord_y_w-1:0]     circle_y,
    input  logic [mover_pkg::coord_x_w-1:0]     hexagon_x,
    input  logic [mover_pkg::coord_y_w-1:0]     hexagon_y,
    output mover_pkg::color_t                   color_select,
    input  logic                                process_ok,
    input  logic                                en,
    input  logic                                move_to_home,
    output logic                                pump_enable,
    output logic                                mov_complete,
    output logic                                sub_module_reset,
    output logic                                uart_pin
);

    logic job_valid;
    logic job_ready;
    logic job_done;
    logic [mover_pkg::coord_x_w-1:0] job_x;
    logic [mover_pkg::coord_y_w-1:0] job_y;
    mover_pkg::color_t job_color;
    mover_pkg::shape_t job_shape;
    logic pick_cmd_valid;
    logic pick_cmd_ready;
    mover_pkg::servo_frame_u pick_cmd_frame;
    logic park_cmd_valid;
    logic park_cmd_ready;
    mover_pkg::servo_frame_u park_cmd_frame;
    logic link_valid;
    logic link_ready;
    mover_pkg::servo_frame_u link_frame;

    job_scheduler job_scheduler_inst (
        .clk_slow(clk_slow),
        .rst_n(rst_n),
        .en(en),
        .process_ok(process_ok),
        .square_x(square_x),
        .circle_x(circle_x),
        .hexagon_x(hexagon_x),
        .square_y(square_y),
        .circle_y(circle_y),
        .hexagon_y(hexagon_y),
        .color_select(color_select),
        .sub_module_reset(sub_module_reset),
        .mov_complete(mov_complete),
        .job_valid(job_valid),
        .job_x(job_x),
        .job_y(job_y),
        .job_color(job_color),
        .job_shape(job_shape),
        .job_ready(job_ready),
        .job_done(job_done)
    );

    pick_place_seq pick_place_seq_inst (
        .clk_slow(clk_slow),
        .rst_n(rst_n),
        .job_valid(job_valid),
        .job_x(job_x),
        .job_y(job_y),
        .job_color(job_color),
        .job_shape(job_shape),
        .job_ready(job_ready),
        .job_done(job_done),
        .cmd_valid(pick_cmd_valid),
        .cmd_frame(pick_cmd_frame),
        .cmd_ready(pick_cmd_ready),
        .pump_enable(pump_enable)
    );

    park_seq park_seq_inst (
        .clk_slow(clk_slow),
        .rst_n(rst_n),
        .move_to_home(move_to_home),
        .cmd_valid(park_cmd_valid),
        .cmd_frame(park_cmd_frame),
        .cmd_ready(park_cmd_ready)
    );

    servo_arbiter servo_arbiter_inst (
        .clk_slow(clk_slow),
        .rst_n(rst_n),
        .park_valid(park_cmd_valid),
        .park_frame(park_cmd_frame),
        .park_ready(park_cmd_ready),
        .pick_valid(pick_cmd_valid),
        .pick_frame(pick_cmd_frame),
        .pick_ready(pick_cmd_ready),
        .link_valid(link_valid),
        .link_frame(link_frame),
        .link_ready(link_ready)
    );

    servo_uart_tx #(
        .baud_div(baud_div),
        .settle_unit(settle_unit)
    ) servo_uart_tx_inst (
        .clk_slow(clk_slow),
        .rst_n(rst_n),
        .link_valid(link_valid),
        .link_frame(link_frame),
        .link_ready(link_ready),
        .uart_pin(uart_pin)
    );

endmodule

// File: servo_link/servo_uart_tx.sv
`timescale 1ns/1ps

module servo_uart_tx #(
    parameter int baud_div = 4,
    parameter int settle_unit = 8
) (
    input  logic                        clk_slow,
    input  logic                        rst_n,
    input  logic                        link_valid,
    input  mover_pkg::servo_frame_u     link_frame,
    output logic                        link_ready,
    output logic                        uart_pin
);

    localparam int baud_w = $clog2(baud_div + 1);
    localparam int settle_w = $clog2(256 * settle_unit + 1);
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_send = 2'd1;
    localparam logic [1:0] st_settle = 2'd2;

    logic [1:0] state;
    mover_pkg::servo_frame_u frame_q;
    logic [9:0] shreg;                                  // stop, data, start
    logic [3:0] bit_cnt;
    logic [2:0] byte_idx;
    logic [baud_w-1:0] baud_cnt;
    logic [settle_w-1:0] settle_cnt;

    assign link_ready = (state == st_idle);
    assign uart_pin = shreg[0];

    always_ff @(posedge clk_slow)
    begin
        if (link_valid && link_ready)
            frame_q <= link_frame;
    end

    always_ff @(posedge clk_slow or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
            shreg <= '1;
            bit_cnt <= '0;
            byte_idx <= '0;
            baud_cnt <= '0;
            settle_cnt <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (link_valid)
                    begin
                        shreg <= {1'b1, link_frame.b[0], 1'b0};
                        bit_cnt <= '0;
                        byte_idx <= '0;
                        baud_cnt <= '0;
                        state <= st_send;
                    end
                end
                st_send:
                begin
                    if (baud_cnt != baud_w'(baud_div - 1))
                        baud_cnt <= baud_cnt + 1'b1;
                    else
                    begin
                        baud_cnt <= '0;
                        if (bit_cnt != 4'd9)
                        begin
                            shreg <= {1'b1, shreg[9:1]};   // lsb first
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                        else if (byte_idx != 3'(mover_pkg::frame_bytes - 1))
                        begin
                            shreg <= {1'b1, frame_q.b[byte_idx + 3'd1], 1'b0};
                            bit_cnt <= '0;
                            byte_idx <= byte_idx + 3'd1;
                        end
                        else
                        begin
                            settle_cnt <= settle_w'(frame_q.f.move_time * settle_unit);
                            state <= st_settle;
                        end
                    end
                end
                st_settle:
                begin
                    if (settle_cnt <= settle_w'(1))
                        state <= st_idle;
                    else
                        settle_cnt <= settle_cnt - 1'b1;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

// File: servo_link/servo_arbiter.sv
`timescale 1ns/1ps

module servo_arbiter (
    input  logic                        clk_slow,
    input  logic                        rst_n,
    input  logic                        park_valid,
    input  mover_pkg::servo_frame_u     park_frame,
    output logic                        park_ready,
    input  logic                        pick_valid,
    input  mover_pkg::servo_frame_u     pick_frame,
    output logic                        pick_ready,
    output logic                        link_valid,
    output mover_pkg::servo_frame_u     link_frame,
    input  logic                        link_ready
);

    logic owned;
    logic sel_park;

    assign link_valid = owned && (sel_park ? park_valid : pick_valid);
    assign link_frame = sel_park ? park_frame : pick_frame;
    assign park_ready = owned && sel_park && link_ready;
    assign pick_ready = owned && !sel_park && link_ready;

    // decide only once the link is free, so park overtakes a waiting pick
    always_ff @(posedge clk_slow or negedge rst_n)
    begin
        if (!rst_n)
        begin
            owned <= 1'b0;
            sel_park <= 1'b0;
        end
        else if (!owned)
        begin
            if (link_ready && (park_valid || pick_valid))
            begin
                owned <= 1'b1;
                sel_park <= park_valid;                 // park wins ties
            end
        end
        else if (link_valid && link_ready)
            owned <= 1'b0;                              // one command per grant
    end

endmodule

// File: sequencer/park_seq.sv
`timescale 1ns/1ps

module park_seq (
    input  logic                        clk_slow,
    input  logic                        rst_n,
    input  logic                        move_to_home,
    output logic                        cmd_valid,
    output mover_pkg::servo_frame_u     cmd_frame,
    input  logic                        cmd_ready
);

    localparam logic [0:3][1:0] park_order = {2'd1, 2'd2, 2'd0, 2'd3};

    logic home_q;
    logic [1:0] idx;
    logic [1:0] joint;

    assign joint = park_order[idx];

    always_comb
    begin
        cmd_frame.f.header = mover_pkg::frame_header;
        cmd_frame.f.id = mover_pkg::servo_id_tbl[joint];
        cmd_frame.f.angle = 16'(mover_pkg::park_angle_tbl[joint]);
        cmd_frame.f.move_time = mover_pkg::park_time;
    end

    always_ff @(posedge clk_slow or negedge rst_n)
    begin
        if (!rst_n)
        begin
            home_q <= 1'b0;
            idx <= 2'd0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            home_q <= move_to_home;
            if (!cmd_valid)
            begin
                if (move_to_home && !home_q)            // rising edge only
                    cmd_valid <= 1'b1;
            end
            else if (cmd_ready)
            begin
                idx <= idx + 2'd1;                      // wraps back to 0 after joint 3
                if (idx == 2'd3)
                    cmd_valid <= 1'b0;
            end
        end
    end

endmodule

// File: sequencer/pick_place_seq.sv
`timescale 1ns/1ps

module pick_place_seq (
    input  logic                                clk_slow,
    input  logic                                rst_n,
    input  logic                                job_valid,
    input  logic [mover_pkg::coord_x_w-1:0]     job_x,
    input  logic [mover_pkg::coord_y_w-1:0]     job_y,
    input  mover_pkg::color_t                   job_color,
    input  mover_pkg::shape_t                   job_shape,
    output logic                                job_ready,
    output logic                                job_done,
    output logic                                cmd_valid,
    output mover_pkg::servo_frame_u             cmd_frame,
    input  logic                                cmd_ready,
    output logic                                pump_enable
);

    localparam int aw = mover_pkg::angle_w;

    logic busy;
    logic [3:0] cmd_idx;
    logic [mover_pkg::coord_x_w-1:0] x_off;
    logic [mover_pkg::coord_y_w-1:0] y_off;
    logic [mover_pkg::coord_x_w-2:0] col;
    logic [mover_pkg::coord_y_w-2:0] row;
    mover_pkg::color_t color_q;
    mover_pkg::shape_t shape_q;
    logic [1:0] joint;
    logic [aw-1:0] angle;
    logic [7:0] move_time;

    assign job_ready = !busy;
    assign x_off = job_x - mover_pkg::grid_x_origin;
    assign y_off = job_y - mover_pkg::grid_y_origin;

    // phases of four: pick, park, place, park
    always_comb
    begin
        joint = cmd_idx[2] ? cmd_idx[1:0] + 2'd1 : 2'd0 - cmd_idx[1:0];  // 1230 or 0321
        if (cmd_idx[2])
        begin
            angle = mover_pkg::park_angle_tbl[joint];
            move_time = mover_pkg::park_time;
        end
        else if (!cmd_idx[3])
        begin
            move_time = mover_pkg::pick_time;
            case (joint)
                2'd1:    angle = mover_pkg::pick_base[joint] + aw'(row);
                2'd2:    angle = mover_pkg::pick_base[joint] - aw'(row);
                default: angle = mover_pkg::pick_base[joint] + aw'(col);
            endcase
        end
        else
        begin
            move_time = mover_pkg::place_time;
            angle = mover_pkg::place_base[joint]
                  + aw'(color_q) * mover_pkg::place_color_step
                  + aw'(shape_q) * mover_pkg::place_shape_step;
        end
    end

    always_comb
    begin
        cmd_frame.f.header = mover_pkg::frame_header;
        cmd_frame.f.id = mover_pkg::servo_id_tbl[joint];
        cmd_frame.f.angle = 16'(angle);
        cmd_frame.f.move_time = move_time;
    end

    always_ff @(posedge clk_slow or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            cmd_idx <= 4'd0;
            cmd_valid <= 1'b0;
            job_done <= 1'b0;
            pump_enable <= 1'b0;
        end
        else
        begin
            job_done <= 1'b0;
            if (!busy)
            begin
                if (job_valid)
                begin
                    busy <= 1'b1;
                    cmd_idx <= 4'd0;
                    cmd_valid <= 1'b1;
                end
            end
            else if (cmd_valid && cmd_ready)
            begin
                if (cmd_idx == 4'd3)
                    pump_enable <= 1'b1;                // grip on joint 1 pick
                if (cmd_idx == 4'd12)
                    pump_enable <= 1'b0;                // release on return park
                cmd_idx <= cmd_idx + 4'd1;
                if (cmd_idx == 4'd15)
                begin
                    busy <= 1'b0;
                    cmd_valid <= 1'b0;
                    job_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_slow)
    begin
        if (job_valid && job_ready)
        begin
            col <= x_off[mover_pkg::coord_x_w-1:1];    // grid cell is 2 units wide
            row <= y_off[mover_pkg::coord_y_w-1:1];
            color_q <= job_color;
            shape_q <= job_shape;
        end
    end

endmodule

// File: sequencer/job_scheduler.sv
`timescale 1ns/1ps

module job_scheduler (
    input  logic                                clk_slow,
    input  logic                                rst_n,
    input  logic                                en,
    input  logic                                process_ok,
    input  logic [mover_pkg::coord_x_w-1:0]     square_x,
    input  logic [mover_pkg::coord_x_w-1:0]     circle_x,
    input  logic [mover_pkg::coord_x_w-1:0]     hexagon_x,
    input  logic [mover_pkg::coord_y_w-1:0]     square_y,
    input  logic [mover_pkg::coord_y_w-1:0]     circle_y,
    input  logic [mover_pkg::coord_y_w-1:0]     hexagon_y,
    output mover_pkg::color_t                   color_select,
    output logic                                sub_module_reset,
    output logic                                mov_complete,
    output logic                                job_valid,
    output logic [mover_pkg::coord_x_w-1:0]     job_x,
    output logic [mover_pkg::coord_y_w-1:0]     job_y,
    output mover_pkg::color_t                   job_color,
    output mover_pkg::shape_t                   job_shape,
    input  logic                                job_ready,
    input  logic                                job_done
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_reset = 3'd1;
    localparam logic [2:0] st_wait_ok = 3'd2;
    localparam logic [2:0] st_select = 3'd3;
    localparam logic [2:0] st_offer = 3'd4;
    localparam logic [2:0] st_busy = 3'd5;
    localparam logic [2:0] st_next = 3'd6;

    logic [2:0] state;
    logic rst_cnt;
    mover_pkg::shape_t shape_idx;
    logic [mover_pkg::coord_x_w-1:0] cur_x;
    logic [mover_pkg::coord_y_w-1:0] cur_y;
    logic present;

    always_comb
    begin
        case (shape_idx)
            mover_pkg::shape_square:
            begin
                cur_x = square_x;
                cur_y = square_y;
            end
            mover_pkg::shape_circle:
            begin
                cur_x = circle_x;
                cur_y = circle_y;
            end
            default:
            begin
                cur_x = hexagon_x;
                cur_y = hexagon_y;
            end
        endcase
    end

    assign present = (cur_x != '0) && (cur_y != '0);    // zero means no such shape

    always_ff @(posedge clk_slow or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
            color_select <= mover_pkg::color_red;
            shape_idx <= mover_pkg::shape_square;
            rst_cnt <= 1'b0;
            sub_module_reset <= 1'b0;
            mov_complete <= 1'b0;
            job_valid <= 1'b0;
        end
        else if (!en)
        begin
            state <= st_idle;
            color_select <= mover_pkg::color_red;
            sub_module_reset <= 1'b0;
            mov_complete <= 1'b0;
            job_valid <= 1'b0;
        end
        else
        begin
            mov_complete <= 1'b0;
            case (state)
                st_idle:
                begin
                    sub_module_reset <= 1'b1;
                    rst_cnt <= 1'b0;
                    state <= st_reset;
                end
                st_reset:
                begin
                    rst_cnt <= 1'b1;
                    if (rst_cnt)                        // second cycle of the pulse
                    begin
                        sub_module_reset <= 1'b0;
                        state <= st_wait_ok;
                    end
                end
                st_wait_ok:
                begin
                    if (process_ok)
                    begin
                        shape_idx <= mover_pkg::shape_square;
                        state <= st_select;
                    end
                end
                st_select:
                begin
                    job_valid <= present;
                    state <= present ? st_offer : st_next;
                end
                st_offer:
                begin
                    if (job_ready)
                    begin
                        job_valid <= 1'b0;
                        state <= st_busy;
                    end
                end
                st_busy:
                begin
                    if (job_done)
                        state <= st_next;
                end
                st_next:
                begin
                    if (shape_idx == mover_pkg::shape_hexagon)
                    begin
                        mov_complete <= 1'b1;
                        color_select <= color_select + 2'd1;    // black wraps to red
                        sub_module_reset <= 1'b1;
                        rst_cnt <= 1'b0;
                        state <= st_reset;
                    end
                    else
                    begin
                        shape_idx <= shape_idx + 2'd1;
                        state <= st_select;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_slow)
    begin
        if (state == st_select && present)
        begin
            job_x <= cur_x;
            job_y <= cur_y;
            job_color <= color_select;
            job_shape <= shape_idx;
        end
    end

endmodule

// File: common/mover_pkg.sv
package mover_pkg;

    localparam int coord_x_w = 9;
    localparam int coord_y_w = 8;
    localparam int angle_w = 12;

    typedef logic [1:0] color_t;
    typedef logic [1:0] shape_t;

    localparam color_t color_red = 2'd0;
    localparam color_t color_blue = 2'd1;
    localparam color_t color_yellow = 2'd2;
    localparam color_t color_black = 2'd3;

    localparam shape_t shape_square = 2'd0;
    localparam shape_t shape_circle = 2'd1;
    localparam shape_t shape_hexagon = 2'd2;

    localparam logic [7:0] frame_header = 8'h55;
    localparam int frame_bytes = 5;

    typedef union packed {
        struct packed {
            logic [7:0]  header;
            logic [7:0]  id;
            logic [15:0] angle;
            logic [7:0]  move_time;                  // in settle units
        } f;
        logic [0:frame_bytes-1][7:0] b;              // b[0] goes out first
    } servo_frame_u;

    // joint order 0 to 3
    localparam logic [0:3][7:0] servo_id_tbl = {8'd0, 8'd1, 8'd2, 8'd4};
    localparam logic [0:3][angle_w-1:0] park_angle_tbl = {12'd1529, 12'd1840, 12'd1199, 12'd842};
    localparam logic [0:3][angle_w-1:0] pick_base = {12'd1400, 12'd1600, 12'd1300, 12'd900};
    localparam logic [0:3][angle_w-1:0] place_base = {12'd1800, 12'd1500, 12'd1100, 12'd700};

    localparam logic [angle_w-1:0] place_color_step = 12'd64;
    localparam logic [angle_w-1:0] place_shape_step = 12'd16;

    localparam logic [coord_x_w-1:0] grid_x_origin = 9'd83;
    localparam logic [coord_y_w-1:0] grid_y_origin = 8'd100;

    localparam logic [7:0] pick_time = 8'd8;
    localparam logic [7:0] park_time = 8'd3;
    localparam logic [7:0] place_time = 8'd5;

endpackage
